// File: build.f
+incdir+include
hdl/gesture_pkg.sv
hdl/scl_timer.sv
hdl/i2c_bit_engine.sv
hdl/read_sequencer.sv
hdl/gesture_reader_top.sv
test/i2c_sensor_model.sv
test/tb_gesture_reader.sv

// File: hdl/gesture_pkg.sv
`default_nettype none

`include "gesture_consts.svh"

package gesture_pkg;

   typedef enum logic [3:0]
   {
      ST_IDLE,
      ST_START,
      ST_SLAVE_ADDR,
      ST_ADDR_ACK,
      ST_REG,
      ST_REG_ACK,
      ST_RSTART,       // Repeated START before read address
      ST_DATA,
      ST_MASTER_ACK,
      ST_STOP,
      ST_HOLDOFF
   } i2c_state_e;

   typedef struct packed
   {
      logic rise;      // Single-cycle pulse
      logic fall;      // Single-cycle pulse
      logic high;      // Level, SCL settled high
   } scl_mark_t;

   typedef struct packed
   {
      logic                  load;
      logic [`BYTE_BITS-1:0] tx_byte;   // All ones when receiving
      logic                  rx_mode;
      logic                  ack_out;   // 0 = ACK, 1 = NACK
      logic                  run;
   } bit_cmd_t;

   typedef struct packed
   {
      logic                  byte_done;
      logic [`BYTE_BITS-1:0] rx_byte;
      logic                  ack_in;
   } bit_status_t;

   // First byte read sits in the low byte
   typedef logic [`GESTURE_BYTES*`BYTE_BITS-1:0] gesture_flags_t;

endpackage

`default_nettype wire

// File: hdl/gesture_reader_top.sv
`default_nettype none

module gesture_reader_top
(
   input  wire                          Clk_i,
   input  wire                          Reset_i,
   input  wire                          enable_i,
   input  wire                          int_n_i,
   input  wire                          sda_i,
   output logic                         scl_o,
   output logic                         sda_pull_o,   // Open-drain pull request
   output gesture_pkg::gesture_flags_t  gesture_flags_o,
   output logic                         gesture_valid_o,
   output logic                         ack_error_o
);

   gesture_pkg::scl_mark_t   scl_mark;
   gesture_pkg::bit_cmd_t    bit_cmd;
   gesture_pkg::bit_status_t bit_status;
   logic                     timer_run;
   logic                     engine_pull;
   logic                     seq_pull;

   assign sda_pull_o = engine_pull | seq_pull;   // Engine owns bytes, sequencer owns edges

   scl_timer timer0
   (
      .Clk_i   (Clk_i),
      .Reset_i (Reset_i),
      .run_i   (timer_run),
      .scl_o   (scl_o),
      .mark_o  (scl_mark)
   );

   i2c_bit_engine engine0
   (
      .Clk_i      (Clk_i),
      .Reset_i    (Reset_i),
      .mark_i     (scl_mark),
      .cmd_i      (bit_cmd),
      .sda_i      (sda_i),
      .sda_pull_o (engine_pull),
      .status_o   (bit_status)
   );

   read_sequencer seq0
   (
      .Clk_i       (Clk_i),
      .Reset_i     (Reset_i),
      .enable_i    (enable_i),
      .int_n_i     (int_n_i),
      .mark_i      (scl_mark),
      .status_i    (bit_status),
      .run_o       (timer_run),
      .cmd_o       (bit_cmd),
      .sda_pull_o  (seq_pull),
      .flags_o     (gesture_flags_o),
      .valid_o     (gesture_valid_o),
      .ack_error_o (ack_error_o)
   );

endmodule

`default_nettype wire

// File: hdl/i2c_bit_engine.sv
`default_nettype none

`include "gesture_consts.svh"

module i2c_bit_engine
(
   input  wire                       Clk_i,
   input  wire                       Reset_i,
   input  wire gesture_pkg::scl_mark_t mark_i,
   input  wire gesture_pkg::bit_cmd_t  cmd_i,
   input  wire                       sda_i,
   output logic                      sda_pull_o,
   output gesture_pkg::bit_status_t  status_o
);

   localparam int CNT_W = $clog2(`BYTE_BITS + 1);

   logic                  busy_r;
   logic [CNT_W-1:0]      bit_cnt_r;   // 0..7 data, 8 acknowledge
   logic [`BYTE_BITS-1:0] tx_sh_r;
   logic [`BYTE_BITS-1:0] rx_sh_r;
   logic                  ack_in_r;
   logic                  active;
   logic                  ack_bit;

   assign active  = busy_r & cmd_i.run;
   assign ack_bit = (bit_cnt_r == CNT_W'(`BYTE_BITS));

   ////////////////////////////////////////////////////////////
   // Bit counter, advances on each SCL fall
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         busy_r    <= 1'b0;
         bit_cnt_r <= '0;
      end
      else if (cmd_i.load)
      begin
         busy_r    <= 1'b1;
         bit_cnt_r <= '0;
      end
      else if (active && mark_i.fall)
      begin
         if (ack_bit)
            busy_r <= 1'b0;                  // Fall that ends bit 9
         else
            bit_cnt_r <= bit_cnt_r + 1'b1;
      end
   end

   // Shift out after fall, sample on rise
   always_ff @(posedge Clk_i)
   begin
      if (cmd_i.load)
         tx_sh_r <= cmd_i.tx_byte;
      else if (active && mark_i.fall)
         tx_sh_r <= {tx_sh_r[`BYTE_BITS-2:0], 1'b1};

      if (active && mark_i.rise)
      begin
         if (ack_bit)
            ack_in_r <= sda_i;
         else
            rx_sh_r <= {rx_sh_r[`BYTE_BITS-2:0], sda_i};
      end
   end

   always_comb
   begin
      sda_pull_o = 1'b0;
      if (active)
      begin
         if (!ack_bit)
            sda_pull_o = ~tx_sh_r[`BYTE_BITS-1];   // Pull only for zero bits
         else if (cmd_i.rx_mode)
            sda_pull_o = ~cmd_i.ack_out;           // Master ACK pulls low
      end
   end

   assign status_o.byte_done = active & mark_i.fall & ack_bit;
   assign status_o.rx_byte   = rx_sh_r;
   assign status_o.ack_in    = ack_in_r;

endmodule

`default_nettype wire

// File: hdl/read_sequencer.sv
`default_nettype none

`include "gesture_consts.svh"

module read_sequencer
(
   input  wire                          Clk_i,
   input  wire                          Reset_i,
   input  wire                          enable_i,
   input  wire                          int_n_i,
   input  wire gesture_pkg::scl_mark_t    mark_i,
   input  wire gesture_pkg::bit_status_t  status_i,
   output logic                         run_o,
   output gesture_pkg::bit_cmd_t        cmd_o,
   output logic                         sda_pull_o,
   output gesture_pkg::gesture_flags_t  flags_o,
   output logic                         valid_o,
   output logic                         ack_error_o
);

   localparam int IDX_W  = (`GESTURE_BYTES > 1) ? $clog2(`GESTURE_BYTES) : 1;
   localparam int HOLD_W = $clog2(`HOLDOFF_CYCLES + 1);
   localparam int BIT_W  = $clog2(`BYTE_BITS);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`GESTURE_BYTES - 1);

   gesture_pkg::i2c_state_e     state_r;
   logic                        run_r;
   logic                        seq_pull_r;
   logic                        load_r;
   logic                        read_r;      // Second address phase
   logic                        err_r;
   logic                        valid_r;
   logic                        ack_err_r;
   logic [BIT_W-1:0]            fall_cnt_r;
   logic [IDX_W-1:0]            byte_idx_r;
   logic [HOLD_W-1:0]           hold_cnt_r;
   gesture_pkg::gesture_flags_t flags_r;
   gesture_pkg::gesture_flags_t shadow_r;
   logic [`BYTE_BITS-1:0]       tx_r;
   logic [`BYTE_BITS-1:0]       tx_nx;
   logic                        rx_mode_r;
   logic                        rx_nx;
   logic                        ack_out_r;
   logic                        ack_nx;
   logic                        load_go;
   logic                        bits_sent;
   logic                        slave_nack;

   assign bits_sent  = mark_i.fall && (fall_cnt_r == BIT_W'(`BYTE_BITS - 1));
   assign slave_nack = status_i.byte_done & status_i.ack_in;

   ////////////////////////////////////////////////////////////
   // Next byte command, issued right after an SCL fall
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      load_go = 1'b0;
      tx_nx   = '1;
      rx_nx   = 1'b0;
      ack_nx  = 1'b1;
      case (state_r)
         gesture_pkg::ST_START:
            if (mark_i.fall)
            begin
               load_go = 1'b1;
               tx_nx   = {`SLAVE_ADDR, read_r};   // R/W in bit 0
            end
         gesture_pkg::ST_ADDR_ACK:
            if (status_i.byte_done && !status_i.ack_in)
            begin
               load_go = 1'b1;
               if (read_r)
               begin
                  rx_nx  = 1'b1;
                  ack_nx = (LAST_IDX == '0);
               end
               else
                  tx_nx = `GESTURE_REG;
            end
         gesture_pkg::ST_MASTER_ACK:
            if (status_i.byte_done && byte_idx_r != LAST_IDX)
            begin
               load_go = 1'b1;
               rx_nx   = 1'b1;
               ack_nx  = (byte_idx_r + 1'b1 == LAST_IDX);   // NACK the last byte
            end
         default:
            load_go = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Transaction FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         state_r    <= gesture_pkg::ST_IDLE;
         run_r      <= 1'b0;
         seq_pull_r <= 1'b0;
         load_r     <= 1'b0;
         read_r     <= 1'b0;
         err_r      <= 1'b0;
         valid_r    <= 1'b0;
         ack_err_r  <= 1'b0;
         fall_cnt_r <= '0;
         byte_idx_r <= '0;
         hold_cnt_r <= '0;
         flags_r    <= '0;
      end
      else
      begin
         load_r    <= load_go;
         valid_r   <= 1'b0;
         ack_err_r <= 1'b0;
         if (load_go)
            fall_cnt_r <= '0;
         else if (mark_i.fall)
            fall_cnt_r <= fall_cnt_r + 1'b1;

         case (state_r)
            gesture_pkg::ST_IDLE:
               if (enable_i && !int_n_i)
               begin
                  state_r    <= gesture_pkg::ST_START;
                  run_r      <= 1'b1;
                  seq_pull_r <= 1'b1;                   // START, SCL still high
                  read_r     <= 1'b0;
                  err_r      <= 1'b0;
               end
            gesture_pkg::ST_START:
               if (mark_i.fall)
               begin
                  state_r    <= gesture_pkg::ST_SLAVE_ADDR;
                  seq_pull_r <= 1'b0;                   // Engine takes SDA
               end
            gesture_pkg::ST_SLAVE_ADDR:
               if (bits_sent)
                  state_r <= gesture_pkg::ST_ADDR_ACK;
            gesture_pkg::ST_ADDR_ACK:
               if (slave_nack)
               begin
                  state_r    <= gesture_pkg::ST_STOP;
                  seq_pull_r <= 1'b1;
                  err_r      <= 1'b1;
               end
               else if (status_i.byte_done)
               begin
                  state_r    <= read_r ? gesture_pkg::ST_DATA : gesture_pkg::ST_REG;
                  byte_idx_r <= '0;
               end
            gesture_pkg::ST_REG:
               if (bits_sent)
                  state_r <= gesture_pkg::ST_REG_ACK;
            gesture_pkg::ST_REG_ACK:
               if (slave_nack)
               begin
                  state_r    <= gesture_pkg::ST_STOP;
                  seq_pull_r <= 1'b1;
                  err_r      <= 1'b1;
               end
               else if (status_i.byte_done)
                  state_r <= gesture_pkg::ST_RSTART;
            gesture_pkg::ST_RSTART:
               if (mark_i.high)
               begin
                  state_r    <= gesture_pkg::ST_START;
                  seq_pull_r <= 1'b1;                   // SDA falls while SCL high
                  read_r     <= 1'b1;
               end
            gesture_pkg::ST_DATA:
               if (bits_sent)
                  state_r <= gesture_pkg::ST_MASTER_ACK;
            gesture_pkg::ST_MASTER_ACK:
               if (status_i.byte_done)
               begin
                  if (byte_idx_r == LAST_IDX)
                  begin
                     state_r    <= gesture_pkg::ST_STOP;
                     seq_pull_r <= 1'b1;                // Hold SDA low through SCL low
                  end
                  else
                  begin
                     state_r    <= gesture_pkg::ST_DATA;
                     byte_idx_r <= byte_idx_r + 1'b1;
                  end
               end
            gesture_pkg::ST_STOP:
               if (mark_i.high)
               begin
                  state_r    <= gesture_pkg::ST_HOLDOFF;
                  seq_pull_r <= 1'b0;                   // SDA rises while SCL high
                  run_r      <= 1'b0;
                  hold_cnt_r <= '0;
                  valid_r    <= ~err_r;
                  ack_err_r  <= err_r;
                  if (!err_r)
                     flags_r <= shadow_r;
               end
            gesture_pkg::ST_HOLDOFF:
               if (hold_cnt_r == HOLD_W'(`HOLDOFF_CYCLES - 1))
                  state_r <= gesture_pkg::ST_IDLE;
               else
                  hold_cnt_r <= hold_cnt_r + 1'b1;
            default:
               state_r <= gesture_pkg::ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (load_go)
      begin
         tx_r      <= tx_nx;
         rx_mode_r <= rx_nx;
         ack_out_r <= ack_nx;
      end
      if (state_r == gesture_pkg::ST_MASTER_ACK && status_i.byte_done)
         shadow_r[byte_idx_r*`BYTE_BITS +: `BYTE_BITS] <= status_i.rx_byte;
   end

   assign run_o         = run_r;
   assign sda_pull_o    = seq_pull_r;
   assign cmd_o.load    = load_r;
   assign cmd_o.tx_byte = tx_r;
   assign cmd_o.rx_mode = rx_mode_r;
   assign cmd_o.ack_out = ack_out_r;
   assign cmd_o.run     = state_r inside {gesture_pkg::ST_SLAVE_ADDR, gesture_pkg::ST_ADDR_ACK,
                                          gesture_pkg::ST_REG, gesture_pkg::ST_REG_ACK,
                                          gesture_pkg::ST_DATA, gesture_pkg::ST_MASTER_ACK};
   assign flags_o       = flags_r;
   assign valid_o       = valid_r;
   assign ack_error_o   = ack_err_r;

endmodule

`default_nettype wire

// File: hdl/scl_timer.sv
`default_nettype none

`include "gesture_consts.svh"

module scl_timer
(
   input  wire                     Clk_i,
   input  wire                     Reset_i,
   input  wire                     run_i,
   output logic                    scl_o,
   output gesture_pkg::scl_mark_t  mark_o
);

   localparam int CNT_W = $clog2(`SCL_PERIOD);

   logic [CNT_W-1:0] cnt_r;
   logic [CNT_W-1:0] cnt_nx;
   logic             scl_r;
   logic             scl_d_r;

   assign cnt_nx = (cnt_r == CNT_W'(`SCL_PERIOD - 1)) ? '0 : cnt_r + 1'b1;

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         cnt_r   <= '0;
         scl_r   <= 1'b1;
         scl_d_r <= 1'b1;
      end
      else
      begin
         scl_d_r <= scl_r;
         if (run_i)
         begin
            cnt_r <= cnt_nx;
            scl_r <= (cnt_nx < CNT_W'(`SCL_HIGH));   // High for first part of period
         end
         else
         begin
            cnt_r <= '0;
            scl_r <= 1'b1;                           // Bus idles high
         end
      end
   end

   assign scl_o       = scl_r;
   assign mark_o.rise = scl_r & ~scl_d_r;
   assign mark_o.fall = ~scl_r & scl_d_r;
   assign mark_o.high = scl_r & scl_d_r;

endmodule

`default_nettype wire

// File: include/gesture_consts.svh
`ifndef GESTURE_CONSTS_SVH
`define GESTURE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Bus timing in system clocks
////////////////////////////////////////////////////////////
`define SCL_PERIOD       16          // Clocks per SCL period
`define SCL_HIGH         8           // SCL high at start of each period

////////////////////////////////////////////////////////////
// Sensor transaction
////////////////////////////////////////////////////////////
`define SLAVE_ADDR       7'h73       // 7-bit sensor address
`define GESTURE_REG      8'h43       // Gesture flag register
`define GESTURE_BYTES    2           // Bytes per burst
`define BYTE_BITS        8

`define HOLDOFF_CYCLES   64          // Idle clocks after STOP

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_gesture_reader -Mdir obj_dir -f build.f

output="$(./obj_dir/Vtb_gesture_reader)"
echo "${output}"

if grep -qx "Result: PASSED" <<< "${output}"; then
   exit 0
fi
exit 1

// File: test/i2c_sensor_model.sv
`default_nettype none

`include "gesture_consts.svh"

module i2c_sensor_model
(
   input  wire                          Clk_i,
   input  wire                          Reset_i,
   input  wire                          scl_i,
   input  wire                          sda_i,
   input  wire gesture_pkg::gesture_flags_t data_i,
   input  wire                          refuse_i,       // NACK the address bytes
   output logic                         sda_pull_o,
   output logic [`BYTE_BITS-1:0]        wr_addr_o,
   output logic [`BYTE_BITS-1:0]        reg_o,
   output logic [`BYTE_BITS-1:0]        rd_addr_o,
   output logic                         rstart_o,       // Read address followed a repeated START
   output logic [`GESTURE_BYTES-1:0]    master_ack_o,   // 0 = ACK per data byte
   output int                           start_cnt_o
);

   logic                  scl_q;
   logic                  sda_q;
   logic                  in_frame;   // Between START and STOP
   logic                  repeated;
   logic                  reading;
   logic                  acked;
   logic                  sending;
   logic [`BYTE_BITS-1:0] rx_sh;
   logic [`BYTE_BITS-1:0] tx_sh;
   int                    bit_cnt;    // -1 before first bit, 8 on acknowledge
   int                    byte_cnt;
   int                    rd_idx;

   // Bus sampled on the falling system clock, away from DUT updates
   always @(negedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         scl_q        = 1'b1;
         sda_q        = 1'b1;
         in_frame     = 1'b0;
         repeated     = 1'b0;
         reading      = 1'b0;
         acked        = 1'b0;
         sending      = 1'b0;
         rx_sh        = '0;
         tx_sh        = '1;
         bit_cnt      = -1;
         byte_cnt     = 0;
         rd_idx       = 0;
         sda_pull_o   = 1'b0;
         wr_addr_o    = '0;
         reg_o        = '0;
         rd_addr_o    = '0;
         rstart_o     = 1'b0;
         master_ack_o = '1;
         start_cnt_o  = 0;
      end
      else
      begin
         if (scl_i && scl_q && sda_q && !sda_i)
         begin
            repeated = in_frame;
            if (!in_frame)
            begin
               wr_addr_o    = '0;                 // New transaction
               reg_o        = '0;
               rd_addr_o    = '0;
               rstart_o     = 1'b0;
               master_ack_o = '1;
            end
            in_frame    = 1'b1;
            bit_cnt     = -1;
            byte_cnt    = 0;
            sending     = 1'b0;
            start_cnt_o = start_cnt_o + 1;
         end
         else if (scl_i && scl_q && !sda_q && sda_i)
         begin
            in_frame   = 1'b0;                    // STOP
            sending    = 1'b0;
            sda_pull_o = 1'b0;
         end
         else if (in_frame && scl_i && !scl_q)
         begin
            if (bit_cnt >= 0 && bit_cnt < `BYTE_BITS)
               rx_sh = {rx_sh[`BYTE_BITS-2:0], sda_i};
            else if (bit_cnt == `BYTE_BITS && sending)
               master_ack_o[rd_idx] = sda_i;
         end
         else if (in_frame && !scl_i && scl_q)
         begin
            ////////////////////////////////////////////////////////////
            // SCL fall, move to the next bit
            ////////////////////////////////////////////////////////////
            if (bit_cnt < `BYTE_BITS - 1)
            begin
               bit_cnt = bit_cnt + 1;
               if (sending)
               begin
                  tx_sh      = {tx_sh[`BYTE_BITS-2:0], 1'b1};
                  sda_pull_o = ~tx_sh[`BYTE_BITS-1];
               end
            end
            else if (bit_cnt == `BYTE_BITS - 1)
            begin
               bit_cnt = `BYTE_BITS;
               if (sending)
                  sda_pull_o = 1'b0;              // Master drives acknowledge
               else if (byte_cnt == 0)
               begin
                  reading = rx_sh[0];
                  if (reading)
                  begin
                     rd_addr_o = rx_sh;
                     rstart_o  = repeated;
                  end
                  else
                     wr_addr_o = rx_sh;
                  acked      = !refuse_i;
                  sda_pull_o = acked;
               end
               else
               begin
                  if (!reading)
                     reg_o = rx_sh;
                  sda_pull_o = 1'b1;
               end
            end
            else
            begin
               bit_cnt = 0;                       // End of acknowledge bit
               if (sending && !master_ack_o[rd_idx] && rd_idx < `GESTURE_BYTES - 1)
               begin
                  rd_idx     = rd_idx + 1;
                  tx_sh      = data_i[rd_idx*`BYTE_BITS +: `BYTE_BITS];
                  sda_pull_o = ~tx_sh[`BYTE_BITS-1];
               end
               else if (!sending && byte_cnt == 0 && reading && acked)
               begin
                  sending    = 1'b1;
                  rd_idx     = 0;
                  tx_sh      = data_i[`BYTE_BITS-1:0];
                  sda_pull_o = ~tx_sh[`BYTE_BITS-1];
               end
               else
               begin
                  sending    = 1'b0;
                  sda_pull_o = 1'b0;
               end
               byte_cnt = byte_cnt + 1;
            end
         end
         scl_q = scl_i;
         sda_q = sda_i;
      end
   end

endmodule

`default_nettype wire

// File: test/tb_gesture_reader.sv
`default_nettype none

`include "gesture_consts.svh"

module tb_gesture_reader;

   localparam int          NUM_ROWS    = 10;
   localparam int          TXN_TIMEOUT = 2000;   // One transaction plus hold-off
   localparam int          IDLE_WATCH  = 4000;
   localparam logic [1:0]  OUT_NONE    = 2'd0;
   localparam logic [1:0]  OUT_VALID   = 2'd1;
   localparam logic [1:0]  OUT_ERROR   = 2'd2;
   localparam logic [31:0] SEED        = 32'h192c2dea;

   typedef struct packed
   {
      gesture_pkg::gesture_flags_t data;
      logic                        rand_fill;
      logic                        nack_addr;
      logic                        enable;
      logic                        int_n;
      logic                        back_to_back;   // Interrupt stays low after the pulse
      logic [1:0]                  outcome;
   } stim_row_t;

   logic                        clk;
   logic                        reset_n;
   logic                        enable;
   logic                        int_n;
   logic                        sda;
   logic                        scl;
   logic                        dut_pull;
   logic                        model_pull;
   gesture_pkg::gesture_flags_t flags;
   logic                        valid;
   logic                        ack_error;
   gesture_pkg::gesture_flags_t model_data;
   logic                        model_refuse;
   logic [`BYTE_BITS-1:0]       seen_wr_addr;
   logic [`BYTE_BITS-1:0]       seen_reg;
   logic [`BYTE_BITS-1:0]       seen_rd_addr;
   logic                        seen_rstart;
   logic [`GESTURE_BYTES-1:0]   seen_master_ack;
   int                          seen_starts;

   stim_row_t                   rows [NUM_ROWS];
   gesture_pkg::gesture_flags_t last_flags;
   logic [31:0]                 rng_state;
   int                          check_count;
   int                          error_count;
   int                          timeout_count;

   assign sda = ~(dut_pull | model_pull);   // Open-drain wired-AND

   always #5 clk = ~clk;

   gesture_reader_top dut0
   (
      .Clk_i           (clk),
      .Reset_i         (reset_n),
      .enable_i        (enable),
      .int_n_i         (int_n),
      .sda_i           (sda),
      .scl_o           (scl),
      .sda_pull_o      (dut_pull),
      .gesture_flags_o (flags),
      .gesture_valid_o (valid),
      .ack_error_o     (ack_error)
   );

   i2c_sensor_model sensor0
   (
      .Clk_i        (clk),
      .Reset_i      (reset_n),
      .scl_i        (scl),
      .sda_i        (sda),
      .data_i       (model_data),
      .refuse_i     (model_refuse),
      .sda_pull_o   (model_pull),
      .wr_addr_o    (seen_wr_addr),
      .reg_o        (seen_reg),
      .rd_addr_o    (seen_rd_addr),
      .rstart_o     (seen_rstart),
      .master_ack_o (seen_master_ack),
      .start_cnt_o  (seen_starts)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count = check_count + 1;
      if (got !== expected)
      begin
         error_count = error_count + 1;
         $display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
      end
   endtask

   task automatic wait_for_pulse(output logic got_valid, output logic got_error,
                                 output logic timed_out);
      int n;
      got_valid = 1'b0;
      got_error = 1'b0;
      timed_out = 1'b1;
      n         = 0;
      while (timed_out && n < TXN_TIMEOUT)
      begin
         @(negedge clk);
         n = n + 1;
         if (valid || ack_error)
         begin
            got_valid = valid;
            got_error = ack_error;
            timed_out = 1'b0;
         end
      end
   endtask

   task automatic watch_bus_idle(output logic busy);
      int n;
      busy = 1'b0;
      for (n = 0; n < IDLE_WATCH; n++)
      begin
         @(negedge clk);
         if (valid || ack_error || !scl || dut_pull)
            busy = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   // Columns: data, random fill, NACK address, enable, int_n, back to back, outcome
   ////////////////////////////////////////////////////////////
   task automatic fill_rows();
      rows[0] = '{16'h3CA5, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, OUT_VALID};
      rows[1] = '{16'h80FF, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, OUT_VALID};
      rows[2] = '{16'h1234, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, OUT_ERROR};
      rows[3] = '{16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, OUT_NONE};    // Disabled
      rows[4] = '{16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, OUT_NONE};    // No interrupt
      rows[5] = '{16'h0000, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, OUT_VALID};
      rows[6] = '{16'h0000, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, OUT_VALID};
      rows[7] = '{16'h0000, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, OUT_VALID};
      rows[8] = '{16'h0000, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, OUT_VALID};
      rows[9] = '{16'h5A5A, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, OUT_ERROR};
   endtask

   task automatic run_row(input int r);
      stim_row_t                 row;
      logic                      got_valid;
      logic                      got_error;
      logic                      timed_out;
      logic                      bus_busy;
      int                        starts_before;
      int                        i;
      logic [`GESTURE_BYTES-1:0] exp_ack;
      row = rows[r];
      if (row.rand_fill)
      begin
         rng_state = xorshift32(rng_state);
         row.data  = rng_state[`GESTURE_BYTES*`BYTE_BITS-1:0];
      end
      @(negedge clk);
      model_data   = row.data;
      model_refuse = row.nack_addr;
      enable       = row.enable;
      int_n        = row.int_n;
      if (row.outcome == OUT_NONE)
      begin
         starts_before = seen_starts;
         watch_bus_idle(bus_busy);
         check_value("bus_activity", 32'(bus_busy), 32'd0);
         check_value("start_count", 32'(seen_starts), 32'(starts_before));
      end
      else
      begin
         wait_for_pulse(got_valid, got_error, timed_out);
         if (timed_out)
         begin
            timeout_count = timeout_count + 1;
            $display("Row %0d: no valid or error pulse came before the timeout", r);
         end
         else
         begin
            if (!row.back_to_back)
               int_n = 1'b1;
            check_value("gesture_valid_o", 32'(got_valid), 32'(row.outcome == OUT_VALID));
            check_value("ack_error_o", 32'(got_error), 32'(row.outcome == OUT_ERROR));
            check_value("scl_o", 32'(scl), 32'd1);                  // Bus released after STOP
            check_value("sda_pull_o", 32'(dut_pull), 32'd0);
            if (row.outcome == OUT_VALID)
            begin
               last_flags = row.data;
               for (i = 0; i < `GESTURE_BYTES; i++)
                  exp_ack[i] = (i == `GESTURE_BYTES - 1);         // NACK only the last byte
               check_value("wr_addr", 32'(seen_wr_addr), 32'({`SLAVE_ADDR, 1'b0}));
               check_value("reg_addr", 32'(seen_reg), 32'(`GESTURE_REG));
               check_value("rd_addr", 32'(seen_rd_addr), 32'({`SLAVE_ADDR, 1'b1}));
               check_value("repeated_start", 32'(seen_rstart), 32'd1);
               check_value("master_ack", 32'(seen_master_ack), 32'(exp_ack));
            end
            check_value("gesture_flags_o", 32'(flags), 32'(last_flags));
         end
      end
   endtask

   initial
   begin
      int r;
      clk           = 1'b0;
      reset_n       = 1'b0;
      enable        = 1'b0;
      int_n         = 1'b1;
      model_data    = '0;
      model_refuse  = 1'b0;
      last_flags    = '0;
      rng_state     = SEED;
      check_count   = 0;
      error_count   = 0;
      timeout_count = 0;
      fill_rows();

      repeat (2) @(negedge clk);
      check_value("scl_o", 32'(scl), 32'd1);
      check_value("sda_pull_o", 32'(dut_pull), 32'd0);
      check_value("gesture_valid_o", 32'(valid), 32'd0);
      check_value("ack_error_o", 32'(ack_error), 32'd0);
      check_value("gesture_flags_o", 32'(flags), 32'd0);
      reset_n = 1'b1;

      for (r = 0; r < NUM_ROWS; r++)
         run_row(r);

      $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
               timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
